//--- files.f
+incdir+tb
verilog/mf_pkg.sv
verilog/sample_window.sv
verilog/tone_correlator.sv
verilog/bit_decision.sv
verilog/matched_filter_top.sv
tb/tb_matched_filter.sv

//--- tb/mf_model.svh
`ifndef MF_MODEL_SVH
`define MF_MODEL_SVH

// Copy of the DUT window with the newest sample at WINDOW_LEN-1
sample_t     mw_i [WINDOW_LEN];
sample_t     mw_q [WINDOW_LEN];
logic [31:0] lfsr_state;

// Galois form of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// One LFSR step for each bit handed out
function logic [31:0] take_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int b = 0; b < n; b++) begin
        r = {r[30:0], lfsr_state[0]};
        lfsr_state = lfsr_next(lfsr_state);
    end
    return r;
endfunction

function void model_clear();
    for (int k = 0; k < WINDOW_LEN; k++) begin
        mw_i[k] = '0;
        mw_q[k] = '0;
    end
endfunction

function void model_push(sample_t i, sample_t q);
    for (int k = 0; k < WINDOW_LEN - 1; k++) begin
        mw_i[k] = mw_i[k+1];
        mw_q[k] = mw_q[k+1];
    end
    mw_i[WINDOW_LEN-1] = i;
    mw_q[WINDOW_LEN-1] = q;
endfunction

// 802.15.4 shares the 2/3 MHz pair with default BLE
function automatic tone_t model_tone(mf_mode_t mode, int slot);
    case (mode)
        mode_ble_1p5_2: return (slot != 0) ? tone_2m : tone_1p5m;
        mode_ble_1_1p5: return (slot != 0) ? tone_1p5m : tone_1m;
        default:        return (slot != 0) ? tone_3m : tone_2m;
    endcase
endfunction

function automatic coef_t model_coef(tone_t tone, logic sine, int idx);
    case (tone)
        tone_1m:   return sine ? SIN_1M[idx] : COS_1M[idx];
        tone_1p5m: return sine ? SIN_1P5M[idx] : COS_1P5M[idx];
        tone_2m:   return sine ? SIN_2M[idx] : COS_2M[idx];
        default:   return sine ? SIN_3M[idx] : COS_3M[idx];
    endcase
endfunction

function automatic longint model_energy(mf_mode_t mode, int slot);
    longint acc_ic;
    longint acc_is;
    longint acc_qc;
    longint acc_qs;
    longint c;
    longint s;
    tone_t  tone;
    int     first;
    tone   = model_tone(mode, slot);
    // Only the newest ZIGBEE_LEN samples count in 802.15.4
    first  = (mode == mode_zigbee_2_3) ? WINDOW_LEN - ZIGBEE_LEN : 0;
    acc_ic = 0;
    acc_is = 0;
    acc_qc = 0;
    acc_qs = 0;
    for (int k = first; k < WINDOW_LEN; k++) begin
        c = model_coef(tone, 1'b0, k - first);
        s = model_coef(tone, 1'b1, k - first);
        acc_ic = acc_ic + longint'(mw_i[k]) * c;
        acc_is = acc_is + longint'(mw_i[k]) * s;
        acc_qc = acc_qc + longint'(mw_q[k]) * c;
        acc_qs = acc_qs + longint'(mw_q[k]) * s;
    end
    return acc_ic * acc_ic + acc_is * acc_is + acc_qc * acc_qc + acc_qs * acc_qs;
endfunction

// Bit 0 only when the low tone is strictly stronger
function automatic logic model_bit(mf_mode_t mode);
    return (model_energy(mode, 0) > model_energy(mode, 1)) ? 1'b0 : 1'b1;
endfunction

`endif

//--- tb/tb_matched_filter.sv
`timescale 1ns/1ps
`default_nettype none

module tb_matched_filter;

    import mf_pkg::*;

    localparam int DRAIN_TIMEOUT = 100;

    logic     clk;
    logic     rst;
    logic     in_valid;
    sample_t  in_i;
    sample_t  in_q;
    mf_mode_t in_mode;
    logic     in_decide;
    logic     bit_valid;
    logic     bit_value;

    int   errors;
    int   decides_sent;
    int   bits_seen;
    logic exp_q [$];

    `include "mf_model.svh"

    matched_filter_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_i      (in_i),
        .in_q      (in_q),
        .in_mode   (in_mode),
        .in_decide (in_decide),
        .bit_valid (bit_valid),
        .bit_value (bit_value)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Compare and drive helpers
    ////////////////////////////////////////////////////////////

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s expected %0b, actual %0b", $time, name, exp, act);
        end
    endtask

    // Model's low > high flag against the bit the tone should give
    task automatic check_order(string name, logic exp, logic act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s expected %0b, actual %0b", $time, name, exp, act);
        end
    endtask

    // Each bit_valid takes the oldest pending decision
    always @(negedge clk) begin
        if (rst && bit_valid) begin
            bits_seen++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("Error at %0t: bit_valid with no decision pending", $time);
            end else begin
                check_bit("bit_value", exp_q.pop_front(), bit_value);
            end
        end
    end

    task automatic send_sample(sample_t i, sample_t q, mf_mode_t mode, logic decide);
        in_valid  = 1'b1;
        in_i      = i;
        in_q      = q;
        in_mode   = mode;
        in_decide = decide;
        model_push(i, q);
        if (decide) begin
            exp_q.push_back(model_bit(mode));
            decides_sent++;
        end
        @(posedge clk);
        #1;
        in_valid  = 1'b0;
        in_decide = 1'b0;
    endtask

    task automatic wait_bits();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < DRAIN_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("Error at %0t: timed out, no bit arrived for %0d decisions",
                     $time, exp_q.size());
            exp_q.delete();
        end
        @(posedge clk);
        #1;
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset();
        sample_t si;
        sample_t sq;
        repeat (4) begin
            @(negedge clk);
            check_bit("bit_valid", 1'b0, bit_valid);
            check_bit("bit_value", 1'b0, bit_value);
        end
        @(posedge clk);
        #1;
        si = sample_t'(take_bits(4));
        sq = sample_t'(take_bits(4));
        send_sample(si, sq, mode_ble_2_3, 1'b1);
        wait_bits();
    endtask

    task automatic tone_test(mf_mode_t mode, tone_t tone, logic expect_bit);
        sample_t si;
        sample_t sq;
        for (int n = 0; n < WINDOW_LEN; n++) begin
            // Half the template amplitude fits a 4-bit sample
            si = sample_t'(tone_coef(tone, 1'b0, n) >>> 1);
            sq = sample_t'(tone_coef(tone, 1'b1, n) >>> 1);
            send_sample(si, sq, mode, n == WINDOW_LEN - 1);
        end
        check_order("model_bit", expect_bit, model_bit(mode));
        wait_bits();
    endtask

    // Noise in the older half must not move the decision
    task automatic zigbee_test(tone_t tone, logic expect_bit);
        sample_t si;
        sample_t sq;
        for (int n = 0; n < WINDOW_LEN - ZIGBEE_LEN; n++) begin
            si = sample_t'(take_bits(4));
            sq = sample_t'(take_bits(4));
            send_sample(si, sq, mode_zigbee_2_3, 1'b0);
        end
        for (int n = 0; n < ZIGBEE_LEN; n++) begin
            si = sample_t'(tone_coef(tone, 1'b0, n) >>> 1);
            sq = sample_t'(tone_coef(tone, 1'b1, n) >>> 1);
            send_sample(si, sq, mode_zigbee_2_3, n == ZIGBEE_LEN - 1);
        end
        check_order("model_bit", expect_bit, model_bit(mode_zigbee_2_3));
        wait_bits();
    endtask

    task automatic random_stream(mf_mode_t mode, int count, logic gaps);
        sample_t si;
        sample_t sq;
        int      dec_start;
        int      bits_start;
        int      idle;
        dec_start  = decides_sent;
        bits_start = bits_seen;
        for (int n = 0; n < count; n++) begin
            si = sample_t'(take_bits(4));
            sq = sample_t'(take_bits(4));
            send_sample(si, sq, mode, 1'b1);
            idle = gaps ? int'(take_bits(2)) : 0;
            repeat (idle) begin
                @(posedge clk);
                #1;
            end
        end
        wait_bits();
        if (bits_seen - bits_start != decides_sent - dec_start) begin
            errors++;
            $display("Error at %0t: %0d bits received for %0d decide samples", $time,
                     bits_seen - bits_start, decides_sent - dec_start);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        rst          = 1'b0;
        in_valid     = 1'b0;
        in_i         = '0;
        in_q         = '0;
        in_mode      = mode_ble_2_3;
        in_decide    = 1'b0;
        errors       = 0;
        decides_sent = 0;
        bits_seen    = 0;
        lfsr_state   = 32'h900a_e6a3;
        model_clear();
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b1;

        test_reset();

        tone_test(mode_ble_1_1p5, tone_1m, 1'b0);
        tone_test(mode_ble_1_1p5, tone_1p5m, 1'b1);
        tone_test(mode_ble_1p5_2, tone_1p5m, 1'b0);
        tone_test(mode_ble_1p5_2, tone_2m, 1'b1);
        tone_test(mode_ble_2_3, tone_2m, 1'b0);
        tone_test(mode_ble_2_3, tone_3m, 1'b1);

        zigbee_test(tone_2m, 1'b0);
        zigbee_test(tone_3m, 1'b1);

        random_stream(mode_ble_2_3, 40, 1'b0);
        random_stream(mode_zigbee_2_3, 40, 1'b0);
        random_stream(mode_ble_1p5_2, 40, 1'b0);
        random_stream(mode_ble_1_1p5, 40, 1'b0);

        // Idle cycles between samples leave the window alone
        random_stream(mode_ble_1_1p5, 30, 1'b1);
        random_stream(mode_zigbee_2_3, 30, 1'b1);

        $display("Done: %0d errors, %0d bits checked", errors, bits_seen);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/bit_decision.sv
`timescale 1ns/1ps
`default_nettype none

module bit_decision (
    input  logic            clk,
    input  logic            rst,
    input  logic            energy_valid,
    input  logic            energy_decide,
    input  mf_pkg::energy_t low_energy,
    input  mf_pkg::energy_t high_energy,
    input  logic            high_valid,
    output logic            bit_valid,
    output logic            bit_value
);

    import mf_pkg::*;

    logic take;
    logic bit_nxt;

    ////////////////////////////////////////////////////////////
    // Slicer
    ////////////////////////////////////////////////////////////

    assign take = energy_valid & energy_decide;

    // Ties go to the high tone
    assign bit_nxt = (low_energy > high_energy) ? 1'b0 : 1'b1;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            bit_valid <= 1'b0;
            bit_value <= 1'b0;
        end else begin
            bit_valid <= take;
            if (take) begin
                bit_value <= bit_nxt;
            end
        end
    end

    // Low and high slots must deliver their energies together,
    // otherwise the compare mixes two different windows
    a_slots_aligned : assert property (
        @(posedge clk) disable iff (!rst)
        high_valid == energy_valid
    ) else $error("high tone energy out of step with low tone energy");

endmodule

`default_nettype wire

//--- verilog/matched_filter_top.sv
`timescale 1ns/1ps
`default_nettype none

module matched_filter_top #(
    parameter int WIN_LEN = mf_pkg::WINDOW_LEN,
    parameter int ZB_LEN  = mf_pkg::ZIGBEE_LEN,
    parameter int N_TONES = mf_pkg::NUM_TONES
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  mf_pkg::sample_t  in_i,
    input  mf_pkg::sample_t  in_q,
    input  mf_pkg::mf_mode_t in_mode,
    input  logic             in_decide,
    output logic             bit_valid,
    output logic             bit_value
);

    import mf_pkg::*;

    logic                  win_valid;
    logic                  win_decide;
    mf_mode_t              win_mode;
    sample_t [WIN_LEN-1:0] win_i;
    sample_t [WIN_LEN-1:0] win_q;

    logic [N_TONES-1:0]    energy_valid;
    logic [N_TONES-1:0]    energy_decide;
    energy_t               energy [N_TONES];

    ////////////////////////////////////////////////////////////
    // Sample window
    ////////////////////////////////////////////////////////////

    sample_window #(
        .WIN_LEN (WIN_LEN)
    ) window_i (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_i       (in_i),
        .in_q       (in_q),
        .in_mode    (in_mode),
        .in_decide  (in_decide),
        .win_valid  (win_valid),
        .win_decide (win_decide),
        .win_mode   (win_mode),
        .win_i      (win_i),
        .win_q      (win_q)
    );

    ////////////////////////////////////////////////////////////
    // One correlator per candidate tone
    ////////////////////////////////////////////////////////////

    for (genvar t = 0; t < N_TONES; t++) begin : g_tone
        tone_correlator #(
            .TONE_SLOT (t),
            .WIN_LEN   (WIN_LEN),
            .ZB_LEN    (ZB_LEN)
        ) corr_i (
            .clk           (clk),
            .rst           (rst),
            .win_valid     (win_valid),
            .win_decide    (win_decide),
            .win_mode      (win_mode),
            .win_i         (win_i),
            .win_q         (win_q),
            .energy_valid  (energy_valid[t]),
            .energy_decide (energy_decide[t]),
            .energy        (energy[t])
        );
    end

    // Slot 0 is the low tone, the last slot the high tone
    bit_decision decide_i (
        .clk           (clk),
        .rst           (rst),
        .energy_valid  (energy_valid[0]),
        .energy_decide (energy_decide[0]),
        .low_energy    (energy[0]),
        .high_energy   (energy[N_TONES-1]),
        .high_valid    (energy_valid[N_TONES-1]),
        .bit_valid     (bit_valid),
        .bit_value     (bit_value)
    );

endmodule

`default_nettype wire

//--- verilog/mf_pkg.sv
`default_nettype none

package mf_pkg;

    ////////////////////////////////////////////////////////////
    // Widths and sizes
    ////////////////////////////////////////////////////////////

    // Band-pass ADC sample in 4-bit two's complement
    typedef logic signed [3:0]  sample_t;
    // Template coefficient with one bit more than a sample
    typedef logic signed [4:0]  coef_t;
    // 16 products of at most 120 in magnitude fit in 12 bits
    typedef logic signed [11:0] corr_sum_t;
    // Sum of four squares of corr_sum_t
    typedef logic        [25:0] energy_t;

    localparam int WINDOW_LEN = 16;
    localparam int ZIGBEE_LEN = 8;
    localparam int NUM_TONES  = 2;

    // Two-bit mode select codes
    typedef enum logic [1:0] {
        mode_ble_2_3    = 2'd0,
        mode_zigbee_2_3 = 2'd1,
        mode_ble_1p5_2  = 2'd2,
        mode_ble_1_1p5  = 2'd3
    } mf_mode_t;

    typedef enum logic [1:0] {
        tone_1m   = 2'd0,
        tone_1p5m = 2'd1,
        tone_2m   = 2'd2,
        tone_3m   = 2'd3
    } tone_t;

    ////////////////////////////////////////////////////////////
    // Templates sampled at 16 MHz
    ////////////////////////////////////////////////////////////

    localparam coef_t COS_1M [WINDOW_LEN] = '{
        15, 14, 11, 6, 0, -6, -11, -14, -15, -14, -11, -6, 0, 6, 11, 14};
    localparam coef_t SIN_1M [WINDOW_LEN] = '{
        0, 6, 11, 14, 15, 14, 11, 6, 0, -6, -11, -14, -15, -14, -11, -6};

    localparam coef_t COS_1P5M [WINDOW_LEN] = '{
        15, 12, 6, -3, -11, -15, -14, -8, 0, 8, 14, 15, 11, 3, -6, -12};
    localparam coef_t SIN_1P5M [WINDOW_LEN] = '{
        0, 8, 14, 15, 11, 3, -6, -12, -15, -12, -6, 3, 11, 15, 14, 8};

    localparam coef_t COS_2M [WINDOW_LEN] = '{
        15, 11, 0, -11, -15, -11, 0, 11, 15, 11, 0, -11, -15, -11, 0, 11};
    localparam coef_t SIN_2M [WINDOW_LEN] = '{
        0, 11, 15, 11, 0, -11, -15, -11, 0, 11, 15, 11, 0, -11, -15, -11};

    localparam coef_t COS_3M [WINDOW_LEN] = '{
        15, 6, -11, -14, 0, 14, 11, -6, -15, -6, 11, 14, 0, -14, -11, 6};
    localparam coef_t SIN_3M [WINDOW_LEN] = '{
        0, 14, 11, -6, -15, -6, 11, 14, 0, -14, -11, 6, 15, 6, -11, -14};

    ////////////////////////////////////////////////////////////
    // Lookups
    ////////////////////////////////////////////////////////////

    // Cosine coefficient when sine is low, sine coefficient otherwise
    function automatic coef_t tone_coef(tone_t tone, logic sine, int idx);
        coef_t cos_c;
        coef_t sin_c;
        case (tone)
            tone_1m: begin
                cos_c = COS_1M[idx];
                sin_c = SIN_1M[idx];
            end
            tone_1p5m: begin
                cos_c = COS_1P5M[idx];
                sin_c = SIN_1P5M[idx];
            end
            tone_2m: begin
                cos_c = COS_2M[idx];
                sin_c = SIN_2M[idx];
            end
            default: begin
                cos_c = COS_3M[idx];
                sin_c = SIN_3M[idx];
            end
        endcase
        return sine ? sin_c : cos_c;
    endfunction

    // Slot 0 is the low tone (bit 0), slot 1 the high tone (bit 1)
    function automatic tone_t slot_tone(mf_mode_t mode, int slot);
        tone_t low_t;
        tone_t high_t;
        case (mode)
            mode_ble_1p5_2: begin
                low_t  = tone_1p5m;
                high_t = tone_2m;
            end
            mode_ble_1_1p5: begin
                low_t  = tone_1m;
                high_t = tone_1p5m;
            end
            // Both 2/3 MHz modes share the tone pair
            default: begin
                low_t  = tone_2m;
                high_t = tone_3m;
            end
        endcase
        return (slot == 0) ? low_t : high_t;
    endfunction

endpackage

`default_nettype wire

//--- verilog/sample_window.sv
`timescale 1ns/1ps
`default_nettype none

module sample_window #(
    parameter int WIN_LEN = mf_pkg::WINDOW_LEN
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                in_valid,
    input  mf_pkg::sample_t                     in_i,
    input  mf_pkg::sample_t                     in_q,
    input  mf_pkg::mf_mode_t                    in_mode,
    input  logic                                in_decide,
    output logic                                win_valid,
    output logic                                win_decide,
    output mf_pkg::mf_mode_t                    win_mode,
    output mf_pkg::sample_t [WIN_LEN-1:0]       win_i,
    output mf_pkg::sample_t [WIN_LEN-1:0]       win_q
);

    import mf_pkg::*;

    ////////////////////////////////////////////////////////////
    // Window shift
    ////////////////////////////////////////////////////////////

    // Oldest sample sits at index 0, newest at WIN_LEN-1.
    // The window moves only when a sample is accepted.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            win_i <= '0;
            win_q <= '0;
        end else if (in_valid) begin
            win_i <= {in_i, win_i[WIN_LEN-1:1]};
            win_q <= {in_q, win_q[WIN_LEN-1:1]};
        end
    end

    // Mode and decide ride with their sample
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            win_valid  <= 1'b0;
            win_decide <= 1'b0;
            win_mode   <= mode_ble_2_3;
        end else begin
            win_valid <= in_valid;
            if (in_valid) begin
                win_decide <= in_decide;
                win_mode   <= in_mode;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // An unknown mode would select random templates downstream
    a_mode_known : assert property (
        @(posedge clk) disable iff (!rst)
        in_valid |-> !$isunknown(in_mode)
    ) else $error("in_mode has unknown bits on a valid sample");

endmodule

`default_nettype wire

//--- verilog/tone_correlator.sv
`timescale 1ns/1ps
`default_nettype none

module tone_correlator #(
    parameter int TONE_SLOT = 0,
    parameter int WIN_LEN   = mf_pkg::WINDOW_LEN,
    parameter int ZB_LEN    = mf_pkg::ZIGBEE_LEN
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                win_valid,
    input  logic                                win_decide,
    input  mf_pkg::mf_mode_t                    win_mode,
    input  mf_pkg::sample_t [WIN_LEN-1:0]       win_i,
    input  mf_pkg::sample_t [WIN_LEN-1:0]       win_q,
    output logic                                energy_valid,
    output logic                                energy_decide,
    output mf_pkg::energy_t                     energy
);

    import mf_pkg::*;

    // First window index that counts in 802.15.4 mode
    localparam int ZB_FIRST = WIN_LEN - ZB_LEN;

    tone_t     tone;
    logic      zigbee;
    corr_sum_t sum_ic;
    corr_sum_t sum_is;
    corr_sum_t sum_qc;
    corr_sum_t sum_qs;
    energy_t   energy_nxt;

    // Squares stay signed until the result is known to be positive
    function automatic energy_t square(corr_sum_t s);
        logic signed [2*$bits(corr_sum_t)-1:0] sq;
        sq = s * s;
        return energy_t'(sq);
    endfunction

    ////////////////////////////////////////////////////////////
    // Correlation against cos and sin of this slot's tone
    ////////////////////////////////////////////////////////////

    assign tone   = slot_tone(win_mode, TONE_SLOT);
    assign zigbee = (win_mode == mode_zigbee_2_3);

    always_comb begin
        sample_t s_i;
        sample_t s_q;
        coef_t   c_cos;
        coef_t   c_sin;
        int      tidx;
        sum_ic = '0;
        sum_is = '0;
        sum_qc = '0;
        sum_qs = '0;
        s_i    = '0;
        s_q    = '0;
        c_cos  = '0;
        c_sin  = '0;
        tidx   = 0;
        for (int k = 0; k < WIN_LEN; k++) begin
            // 802.15.4 keeps only the newest ZB_LEN samples,
            // lined up with the start of the template
            if (!zigbee || k >= ZB_FIRST) begin
                tidx   = zigbee ? k - ZB_FIRST : k;
                s_i    = win_i[k];
                s_q    = win_q[k];
                c_cos  = tone_coef(tone, 1'b0, tidx);
                c_sin  = tone_coef(tone, 1'b1, tidx);
                sum_ic = sum_ic + s_i * c_cos;
                sum_is = sum_is + s_i * c_sin;
                sum_qc = sum_qc + s_q * c_cos;
                sum_qs = sum_qs + s_q * c_sin;
            end
        end
    end

    // Non-coherent energy does not depend on the tone's phase
    assign energy_nxt = square(sum_ic) + square(sum_is)
                      + square(sum_qc) + square(sum_qs);

    ////////////////////////////////////////////////////////////
    // Output stage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            energy_valid  <= 1'b0;
            energy_decide <= 1'b0;
        end else begin
            energy_valid  <= win_valid;
            energy_decide <= win_valid & win_decide;
        end
    end

    always_ff @(posedge clk) begin
        if (win_valid) begin
            energy <= energy_nxt;
        end
    end

    // Fixed single-cycle latency keeps both slots aligned
    a_one_cycle : assert property (
        @(posedge clk) disable iff (!rst)
        energy_valid == $past(win_valid)
    ) else $error("energy_valid not one cycle after win_valid");

endmodule

`default_nettype wire
